//--- sim.f
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
mem/data_ram.sv
mem/mem_stage.sv
design/mem_wb.sv
design/regfile.sv
design/commit_monitor.sv
design/wb_backend_top.sv
sim/wb_checker.sv
sim/tb_top.sv

//--- sim/tb_top.sv
// Back end testbench
`timescale 1ns/1ps

module tb_top;
    import rv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    localparam int DMEM_WORDS     = 256;
    localparam int NUM_INSTS      = 600;
    localparam int MAX_STALL_RUN  = 3;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * (1 + MAX_STALL_RUN) + 50;
    localparam int TRAP_AT        = 560;

    logic               clk;
    logic               rst_n;
    logic               ex_valid;
    logic [63:0]        ex_pc;
    logic [31:0]        ex_inst;
    logic [XLEN-1:0]    ex_alu;
    logic [XLEN-1:0]    ex_store_data;
    logic               ex_wen;
    logic [STALL_W-1:0] stall;
    logic [4:0]         dbg_raddr;
    logic [XLEN-1:0]    dbg_rdata;
    logic               retire_valid;
    logic [63:0]        retire_pc;
    logic               trap;
    logic [XLEN-1:0]    exit_code;
    logic               idle;
    int                 retire_errs;
    int                 reg_errs;
    int                 trap_errs;
    logic [31:0]        rng_state;
    logic [63:0]        next_pc;
    int                 cycle_cnt;

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // x0 is picked often so that writes to it get exercised.
    function automatic logic [4:0] pick_rd();
        logic [31:0] r;
        r = next_rand();
        return (r[30:28] == 3'd0) ? 5'd0 : r[24:20];
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        dbg_raddr = dbg_raddr + 5'd1;
    endtask

    task automatic drive_idle(input logic [STALL_W-1:0] stall_vec);
        ex_valid = 1'b0;
        ex_wen   = 1'b0;
        ex_inst  = NOP_WORD;
        stall    = stall_vec;
    endtask

    task automatic drive_inst(input logic [31:0] inst, input logic [63:0] alu,
                              input logic [63:0] sdata, input logic wen);
        ex_valid      = 1'b1;
        ex_pc         = next_pc;
        ex_inst       = inst;
        ex_alu        = alu;
        ex_store_data = sdata;
        ex_wen        = wen;
        stall         = '0;
        next_pc       = next_pc + 64'd4;
    endtask

    // a run of hold or flush cycles, with no strobe while it lasts.
    task automatic insert_stalls();
        logic [31:0] r;
        logic [31:0] s;
        int          run;
        r   = next_rand();
        run = (r[31:29] == 3'd0) ? 1 + (r[27:24] % MAX_STALL_RUN) : 0;
        for (int k = 0; k < run; k++) begin
            s = next_rand();
            drive_idle({1'b1, s[31] ? STG_UPPER_MASK : s[27:24]});
            next_cycle();
        end
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  f3;
        logic [7:0]  addr;
        r = next_rand();
        a = next_rand();
        if (r[31:28] < 4'd5) begin
            drive_inst({a[31:15], 3'b000, pick_rd(), 7'b0010011}, rand64(), '0, 1'b1);
        end else if (r[31:28] < 4'd9) begin
            f3 = (r[26:24] == 3'b111) ? F3_D : r[26:24];
            addr = a[23:16] & ~((8'd1 << f3[1:0]) - 8'd1);
            drive_inst({a[31:15], f3, pick_rd(), OPC_LOAD}, {56'd0, addr}, rand64(), 1'b0);
        end else if (r[31:28] < 4'd13) begin
            f3 = {1'b0, r[25:24]};
            addr = a[23:16] & ~((8'd1 << f3[1:0]) - 8'd1);
            drive_inst({a[31:15], f3, a[11:7], OPC_STORE}, {56'd0, addr}, rand64(), 1'b0);
        end else begin
            drive_inst(NOP_WORD, '0, '0, 1'b1);
        end
    endtask

    wb_backend_top #(
        .DMEM_WORDS(DMEM_WORDS)
    ) dut (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .ex_valid_i      (ex_valid),
        .ex_pc_i         (ex_pc),
        .ex_inst_i       (ex_inst),
        .ex_alu_i        (ex_alu),
        .ex_store_data_i (ex_store_data),
        .ex_wen_i        (ex_wen),
        .stall_i         (stall),
        .dbg_raddr_i     (dbg_raddr),
        .dbg_rdata_o     (dbg_rdata),
        .retire_valid_o  (retire_valid),
        .retire_pc_o     (retire_pc),
        .trap_o          (trap),
        .exit_code_o     (exit_code)
    );

    wb_checker u_wb_checker (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .ex_valid_i      (ex_valid),
        .ex_pc_i         (ex_pc),
        .ex_inst_i       (ex_inst),
        .ex_alu_i        (ex_alu),
        .ex_store_data_i (ex_store_data),
        .ex_wen_i        (ex_wen),
        .dbg_raddr_i     (dbg_raddr),
        .dbg_rdata_i     (dbg_rdata),
        .retire_valid_i  (retire_valid),
        .retire_pc_i     (retire_pc),
        .trap_i          (trap),
        .exit_code_i     (exit_code),
        .idle_o          (idle),
        .retire_errs_o   (retire_errs),
        .reg_errs_o      (reg_errs),
        .trap_errs_o     (trap_errs)
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        rng_state     = 32'd48;
        next_pc       = 64'h8000_0000;
        cycle_cnt     = 0;
        dbg_raddr     = 5'd0;
        ex_pc         = '0;
        ex_alu        = '0;
        ex_store_data = '0;
        drive_idle('0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_INSTS; i++) begin
            insert_stalls();
            if (i == TRAP_AT) begin
                drive_inst({12'd0, 5'd0, 3'b000, 5'd10, 7'b0010011}, rand64(), '0, 1'b1);
            end else if (i == TRAP_AT + 1) begin
                drive_inst(EBREAK_WORD, '0, '0, 1'b0);
            end else begin
                issue_random();
            end
            next_cycle();
        end
        drive_idle('0);
        next_cycle();
        while (!idle) begin
            next_cycle();
        end
        // one more edge so that the outputs of the last commit are compared.
        next_cycle();
        $display("error counts: retire %0d, register %0d, trap %0d",
                 retire_errs, reg_errs, trap_errs);
        if ((retire_errs + reg_errs + trap_errs) == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/wb_checker.sv
// Back end scoreboard
`timescale 1ns/1ps

module wb_checker (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        ex_valid_i,
    input  logic [63:0]                 ex_pc_i,
    input  logic [31:0]                 ex_inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_alu_i,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_store_data_i,
    input  logic                        ex_wen_i,
    input  logic [4:0]                  dbg_raddr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] dbg_rdata_i,
    input  logic                        retire_valid_i,
    input  logic [63:0]                 retire_pc_i,
    input  logic                        trap_i,
    input  logic [rv_isa_pkg::XLEN-1:0] exit_code_i,
    output logic                        idle_o,
    output int                          retire_errs_o,
    output int                          reg_errs_o,
    output int                          trap_errs_o
);
    import rv_isa_pkg::*;

    typedef struct packed {
        logic [31:0]     due;
        logic [63:0]     pc;
        logic            ebreak;
        logic            rd_ena;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } commit_t;

    commit_t         pending[$];
    logic [7:0]      model_ram [256];
    logic [XLEN-1:0] model_regs [32];
    logic            exp_retire;
    logic [63:0]     exp_pc;
    logic            exp_trap;
    logic [XLEN-1:0] exp_exit;
    logic [31:0]     edge_cnt;

    task automatic reset_model();
        pending.delete();
        for (int i = 0; i < 256; i++) begin
            model_ram[i] = 8'h00;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_retire    = 1'b0;
        exp_pc        = '0;
        exp_trap      = 1'b0;
        exp_exit      = '0;
        edge_cnt      = '0;
        idle_o        = 1'b1;
        retire_errs_o = 0;
        reg_errs_o    = 0;
        trap_errs_o   = 0;
    endtask

    // outputs seen at an edge were produced by the edge before it.
    task automatic check_outputs();
        logic [XLEN-1:0] exp_rdata;
        exp_rdata = model_regs[dbg_raddr_i];
        if (retire_valid_i !== exp_retire) begin
            $display("ERR retire_valid_o got %h expected %h", retire_valid_i, exp_retire);
            retire_errs_o++;
        end else if (exp_retire && (retire_pc_i !== exp_pc)) begin
            $display("ERR retire_pc_o got %h expected %h", retire_pc_i, exp_pc);
            retire_errs_o++;
        end
        if (trap_i !== exp_trap) begin
            $display("ERR trap_o got %h expected %h", trap_i, exp_trap);
            trap_errs_o++;
        end
        if (exit_code_i !== exp_exit) begin
            $display("ERR exit_code_o got %h expected %h", exit_code_i, exp_exit);
            trap_errs_o++;
        end
        if (dbg_rdata_i !== exp_rdata) begin
            $display("ERR dbg_rdata_o x%0d got %h expected %h", dbg_raddr_i, dbg_rdata_i,
                     exp_rdata);
            reg_errs_o++;
        end
    endtask

    task automatic commit_due();
        commit_t c;
        exp_retire = 1'b0;
        if ((pending.size() != 0) && (pending[0].due == edge_cnt)) begin
            c = pending.pop_front();
            if (!exp_trap && c.ebreak) begin
                exp_trap = 1'b1;
                exp_exit = model_regs[10];
            end else if (!exp_trap) begin
                exp_retire = 1'b1;
                exp_pc     = c.pc;
            end
            if (c.rd_ena) begin
                model_regs[c.rd] = c.data;
            end
        end
    endtask

    task automatic accept_strobe();
        commit_t         c;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [7:0]      addr;
        logic [XLEN-1:0] value;
        int              nbytes;
        opc    = ex_inst_i[6:0];
        f3     = ex_inst_i[14:12];
        addr   = ex_alu_i[7:0];
        nbytes = 1 << f3[1:0];
        value  = ex_alu_i;
        if (opc == OPC_STORE) begin
            for (int b = 0; b < nbytes; b++) begin
                model_ram[addr + b] = ex_store_data_i[8*b +: 8];
            end
        end
        if (opc == OPC_LOAD) begin
            value = '0;
            for (int b = 0; b < 8; b++) begin
                if (b < nbytes) begin
                    value[8*b +: 8] = model_ram[addr + b];
                end else if (!f3[2] && value[8*nbytes-1]) begin
                    value[8*b +: 8] = 8'hff;
                end
            end
        end
        c.due    = edge_cnt + 1;
        c.pc     = ex_pc_i;
        c.ebreak = (ex_inst_i == EBREAK_WORD);
        c.rd     = ex_inst_i[11:7];
        c.rd_ena = ((opc == OPC_LOAD) || ex_wen_i) && (c.rd != 5'd0);
        c.data   = value;
        pending.push_back(c);
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            reset_model();
        end else begin
            edge_cnt = edge_cnt + 1;
            check_outputs();
            commit_due();
            if (ex_valid_i) begin
                accept_strobe();
            end
            idle_o = (pending.size() == 0) && !exp_retire;
        end
    end

endmodule

//--- design/wb_backend_top.sv
// Pipeline back end top level
`timescale 1ns/1ps

module wb_backend_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             ex_valid_i,
    input  logic [63:0]                      ex_pc_i,
    input  logic [31:0]                      ex_inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      ex_alu_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      ex_store_data_i,
    input  logic                             ex_wen_i,
    input  logic [pipe_ctrl_pkg::STALL_W-1:0] stall_i,
    input  logic [4:0]                       dbg_raddr_i,
    output logic [rv_isa_pkg::XLEN-1:0]      dbg_rdata_o,
    output logic                             retire_valid_o,
    output logic [63:0]                      retire_pc_o,
    output logic                             trap_o,
    output logic [rv_isa_pkg::XLEN-1:0]      exit_code_o
);
    import rv_isa_pkg::*;

    logic            mem_valid;
    logic [63:0]     mem_pc;
    logic [31:0]     mem_inst;
    logic            mem_rd_ena;
    logic [4:0]      mem_rd_addr;
    logic [XLEN-1:0] mem_rd_data;
    logic            wb_valid;
    logic [63:0]     wb_pc;
    logic [31:0]     wb_inst;
    logic            wb_rd_ena;
    logic [4:0]      wb_rd_addr;
    logic [XLEN-1:0] wb_rd_data;
    logic [XLEN-1:0] a0;

    mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_mem_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_valid_i      (ex_valid_i),
        .ex_pc_i         (ex_pc_i),
        .ex_inst_i       (ex_inst_i),
        .ex_alu_i        (ex_alu_i),
        .ex_store_data_i (ex_store_data_i),
        .ex_wen_i        (ex_wen_i),
        .mem_valid_o     (mem_valid),
        .mem_pc_o        (mem_pc),
        .mem_inst_o      (mem_inst),
        .mem_rd_ena_o    (mem_rd_ena),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_rd_data_o   (mem_rd_data)
    );

    mem_wb u_mem_wb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .mem_valid_i   (mem_valid),
        .mem_pc_i      (mem_pc),
        .mem_inst_i    (mem_inst),
        .mem_rd_ena_i  (mem_rd_ena),
        .mem_rd_addr_i (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .wb_valid_o    (wb_valid),
        .wb_pc_o       (wb_pc),
        .wb_inst_o     (wb_inst),
        .wb_rd_ena_o   (wb_rd_ena),
        .wb_rd_addr_o  (wb_rd_addr),
        .wb_rd_data_o  (wb_rd_data)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_rd_ena),
        .waddr_i (wb_rd_addr),
        .wdata_i (wb_rd_data),
        .raddr_i (dbg_raddr_i),
        .rdata_o (dbg_rdata_o),
        .a0_o    (a0)
    );

    commit_monitor u_commit_monitor (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_valid_i     (wb_valid),
        .wb_pc_i        (wb_pc),
        .wb_inst_i      (wb_inst),
        .a0_i           (a0),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .trap_o         (trap_o),
        .exit_code_o    (exit_code_o)
    );

endmodule

//--- design/commit_monitor.sv
// Commit monitor
`timescale 1ns/1ps

module commit_monitor (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        wb_valid_i,
    input  logic [63:0]                 wb_pc_i,
    input  logic [31:0]                 wb_inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0] a0_i,
    output logic                        retire_valid_o,
    output logic [63:0]                 retire_pc_o,
    output logic                        trap_o,
    output logic [rv_isa_pkg::XLEN-1:0] exit_code_o
);
    import rv_isa_pkg::*;

    logic is_ebreak;
    logic commit;

    assign is_ebreak = (wb_inst_i == EBREAK_WORD);

    // once the core has trapped nothing retires any more.
    assign commit = wb_valid_i && !trap_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            trap_o         <= 1'b0;
            exit_code_o    <= '0;
        end else begin
            retire_valid_o <= commit && !is_ebreak;
            if (commit && is_ebreak) begin
                trap_o      <= 1'b1;
                exit_code_o <= a0_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            retire_pc_o <= wb_pc_i;
        end
    end

endmodule

//--- design/regfile.sv
// Integer register file
`timescale 1ns/1ps

module regfile (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        we_i,
    input  logic [4:0]                  waddr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
    input  logic [4:0]                  raddr_i,
    output logic [rv_isa_pkg::XLEN-1:0] rdata_o,
    output logic [rv_isa_pkg::XLEN-1:0] a0_o
);
    import rv_isa_pkg::*;

    localparam logic [4:0] REG_A0 = 5'd10;

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_o = (raddr_i == 5'd0) ? '0 : regs[raddr_i];
    assign a0_o    = regs[REG_A0];

    // the memory stage already drops writes to x0.
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        we_i |-> (waddr_i != 5'd0)
    );

endmodule

//--- design/mem_wb.sv
// MEM/WB pipeline register
`timescale 1ns/1ps

module mem_wb (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic [pipe_ctrl_pkg::STALL_W-1:0] stall_i,
    input  logic                             mem_valid_i,
    input  logic [63:0]                      mem_pc_i,
    input  logic [31:0]                      mem_inst_i,
    input  logic                             mem_rd_ena_i,
    input  logic [4:0]                       mem_rd_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]      mem_rd_data_i,
    output logic                             wb_valid_o,
    output logic [63:0]                      wb_pc_o,
    output logic [31:0]                      wb_inst_o,
    output logic                             wb_rd_ena_o,
    output logic [4:0]                       wb_rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0]      wb_rd_data_o
);
    import pipe_ctrl_pkg::*;

    logic stall_wb;
    logic flush_wb;

    assign stall_wb = stall_i[STG_WB];
    assign flush_wb = stall_wb && (stall_i[STG_WB-1:0] == STG_UPPER_MASK);

    // a hold keeps rd_ena so the register file rewrites the same value,
    // but the instruction is only reported once.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o  <= 1'b0;
            wb_rd_ena_o <= 1'b0;
        end else if (flush_wb) begin
            wb_valid_o  <= 1'b0;
            wb_rd_ena_o <= 1'b0;
        end else if (!stall_wb) begin
            wb_valid_o  <= mem_valid_i;
            wb_rd_ena_o <= mem_rd_ena_i;
        end else begin
            wb_valid_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_wb) begin
            wb_pc_o      <= '0;
            wb_inst_o    <= '0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
        end else if (!stall_wb) begin
            wb_pc_o      <= mem_pc_i;
            wb_inst_o    <= mem_inst_i;
            wb_rd_addr_o <= mem_rd_addr_i;
            wb_rd_data_o <= mem_rd_data_i;
        end
    end

    // an instruction handed over while the slot is held or flushed would be lost.
    a_no_strobe_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_wb |-> !mem_valid_i
    );

endmodule

//--- mem/mem_stage.sv
// Memory access stage
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        ex_valid_i,
    input  logic [63:0]                 ex_pc_i,
    input  logic [31:0]                 ex_inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_alu_i,
    input  logic [rv_isa_pkg::XLEN-1:0] ex_store_data_i,
    input  logic                        ex_wen_i,
    output logic                        mem_valid_o,
    output logic [63:0]                 mem_pc_o,
    output logic [31:0]                 mem_inst_o,
    output logic                        mem_rd_ena_o,
    output logic [4:0]                  mem_rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] mem_rd_data_o
);
    import rv_isa_pkg::*;

    inst_t           inst;
    logic            is_load;
    logic            is_store;
    logic            ram_we;
    logic [2:0]      byte_off;
    logic [5:0]      bit_off;
    logic [7:0]      be;
    logic            store_aligned;
    logic [XLEN-1:0] ram_wdata;
    logic [XLEN-1:0] ram_rdata;
    logic [XLEN-1:0] ld_shift;
    logic [XLEN-1:0] ld_data;

    assign inst     = ex_inst_i;
    assign is_load  = (inst.i_form.opcode == OPC_LOAD);
    assign is_store = (inst.s_form.opcode == OPC_STORE);
    assign ram_we   = ex_valid_i && is_store;
    assign byte_off = ex_alu_i[2:0];
    assign bit_off  = {byte_off, 3'b000};

    // store lanes follow the low address bits.
    assign ram_wdata = ex_store_data_i << bit_off;

    always_comb begin
        case (inst.s_form.funct3)
            F3_B: begin
                be            = 8'h01 << byte_off;
                store_aligned = 1'b1;
            end
            F3_H: begin
                be            = 8'h03 << byte_off;
                store_aligned = (byte_off[0] == 1'b0);
            end
            F3_W: begin
                be            = 8'h0f << byte_off;
                store_aligned = (byte_off[1:0] == 2'b00);
            end
            F3_D: begin
                be            = 8'hff;
                store_aligned = (byte_off == 3'b000);
            end
            default: begin
                be            = 8'h00;
                store_aligned = 1'b1;
            end
        endcase
    end

    // bring the addressed bytes down to bit 0, then extend.
    assign ld_shift = ram_rdata >> bit_off;

    always_comb begin
        case (inst.i_form.funct3)
            F3_B:    ld_data = {{(XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
            F3_H:    ld_data = {{(XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
            F3_W:    ld_data = {{(XLEN-32){ld_shift[31]}}, ld_shift[31:0]};
            F3_BU:   ld_data = {{(XLEN-8){1'b0}}, ld_shift[7:0]};
            F3_HU:   ld_data = {{(XLEN-16){1'b0}}, ld_shift[15:0]};
            F3_WU:   ld_data = {{(XLEN-32){1'b0}}, ld_shift[31:0]};
            default: ld_data = ld_shift;
        endcase
    end

    data_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (ex_alu_i),
        .wdata_i (ram_wdata),
        .be_i    (be),
        .we_i    (ram_we),
        .rdata_o (ram_rdata)
    );

    assign mem_valid_o   = ex_valid_i;
    assign mem_pc_o      = ex_pc_i;
    assign mem_inst_o    = ex_inst_i;
    assign mem_rd_addr_o = inst.i_form.rd;
    assign mem_rd_ena_o  = ex_valid_i && (is_load || ex_wen_i) && (inst.i_form.rd != 5'd0);
    assign mem_rd_data_o = is_load ? ld_data : ex_alu_i;

    // the execute stage is trusted to hand over aligned store addresses.
    a_store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ram_we |-> store_aligned
    );

endmodule

//--- mem/data_ram.sv
// Data memory
`timescale 1ns/1ps

module data_ram #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [rv_isa_pkg::XLEN-1:0] addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
    input  logic [7:0]                  be_i,
    input  logic                        we_i,
    output logic [rv_isa_pkg::XLEN-1:0] rdata_o
);
    import rv_isa_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   widx;

    // byte address in, word index taken above the byte offset.
    assign widx = addr_i[3 +: AW];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            for (int b = 0; b < 8; b++) begin
                if (be_i[b]) begin
                    mem[widx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[widx];

    a_widx_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        we_i |-> (addr_i[XLEN-1:3] < DMEM_WORDS)
    );

endmodule

//--- common/pipe_ctrl_pkg.sv
// Pipeline stall control
package pipe_ctrl_pkg;

    // one stall bit per pipeline register, IF/ID at bit 0 up to MEM/WB.
    localparam int STALL_W = 5;

    // position of the MEM/WB stall bit.
    localparam int STG_WB = 4;

    // all stages below MEM/WB stalled together, which the hazard unit
    // uses to request a flush of the writeback slot.
    localparam logic [STG_WB-1:0] STG_UPPER_MASK = 4'b1111;

endpackage

//--- common/rv_isa_pkg.sv
// RV64I ISA definitions
package rv_isa_pkg;

    localparam int XLEN = 64;

    // major opcodes used by the back end.
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 width codes shared by loads and stores.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    // addi x0, x0, 0.
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_form_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_form_t;

    // the same instruction word seen in I-type and S-type layout.
    typedef union packed {
        i_form_t i_form;
        s_form_t s_form;
    } inst_t;

endpackage
